//--- profiler_cfg_pkg.sv
package profiler_cfg_pkg;

  // Free-running cycle timestamp
  typedef logic [31:0] stamp_t;

  // Measured duration in clock cycles, as carried in a report
  typedef logic [23:0] cycles_t;

  // Retired instruction word seen at writeback
  typedef logic [31:0] instr_t;

  // Both sentinels are addi x0 forms with a marker immediate
  localparam instr_t SENTINEL_START = 32'h5AA0_0013;
  localparam instr_t SENTINEL_END   = 32'h5FF0_0013;

  // The start/end sentinel pair itself costs one cycle
  localparam stamp_t SENTINEL_OVERHEAD = 32'd1;

  // Tile index width covers a 4x4 grid
  localparam int unsigned TILE_ID_W = 4;

  typedef logic [TILE_ID_W-1:0] tile_id_t;

endpackage

//--- report_pkg.sv
package report_pkg;

  // What a report describes
  typedef enum logic [1:0] {
    LATENCY     = 2'd0,
    ORPHAN      = 2'd1,
    SYNC_GLOBAL = 2'd2,
    SYNC_ROW    = 2'd3
  } report_kind_e;

  // One writeback beat from a tile
  typedef struct packed {
    logic                     valid;
    profiler_cfg_pkg::instr_t instr;
  } wb_beat_t;

  // Stamps of one completed start/end pair
  typedef struct packed {
    profiler_cfg_pkg::stamp_t start_stamp;
    profiler_cfg_pkg::stamp_t end_stamp;
  } pair_t;

  // Sync reports carry the round number in the tile field
  typedef struct packed {
    report_kind_e               kind;
    profiler_cfg_pkg::tile_id_t tile;
    profiler_cfg_pkg::cycles_t  cycles;
  } report_t;

endpackage

//--- sentinel_tracker.sv
`timescale 1ns/10ps

module sentinel_tracker #(
  parameter profiler_cfg_pkg::tile_id_t TILE_ID = '0
)(
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  report_pkg::wb_beat_t     i_beat,
  input  profiler_cfg_pkg::stamp_t i_stamp,
  output logic                     o_pair_valid,
  output report_pkg::pair_t        o_pair,
  input  logic                     i_pair_ready,
  output logic                     o_rec_valid,
  output report_pkg::report_t      o_rec,
  input  logic                     i_rec_ready,
  output logic                     o_overflow
);
  import profiler_cfg_pkg::*;
  import report_pkg::*;

  logic    start_open_q;
  stamp_t  start_stamp_q;
  logic    pair_pend_q;
  logic    rec_pend_q;
  logic    overflow_q;
  pair_t   pair_q;
  report_t rec_q;

  logic is_start;
  logic is_end;
  logic pair_acc;
  logic rec_acc;
  logic hold_free;
  logic load;

  assign is_start = i_beat.valid && (i_beat.instr == SENTINEL_START);
  assign is_end   = i_beat.valid && (i_beat.instr == SENTINEL_END);

  // Holding register is free if empty or drained this cycle
  assign pair_acc  = pair_pend_q && i_pair_ready;
  assign rec_acc   = rec_pend_q && i_rec_ready;
  assign hold_free = (!pair_pend_q || pair_acc) && (!rec_pend_q || rec_acc);
  assign load      = is_end && hold_free;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      start_open_q <= 1'b0;
      pair_pend_q  <= 1'b0;
      rec_pend_q   <= 1'b0;
      overflow_q   <= 1'b0;
    end else begin
      if (pair_acc) pair_pend_q <= 1'b0;
      if (rec_acc) rec_pend_q <= 1'b0;
      // An end closes the measurement even when its record is dropped
      if (is_start) begin
        start_open_q <= 1'b1;
      end else if (is_end) begin
        start_open_q <= 1'b0;
      end
      if (load) begin
        rec_pend_q  <= 1'b1;
        pair_pend_q <= start_open_q;
      end
      if (is_end && !hold_free) overflow_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (is_start) start_stamp_q <= i_stamp;
    if (load) begin
      pair_q.start_stamp <= start_stamp_q;
      pair_q.end_stamp   <= i_stamp;
      rec_q.kind         <= start_open_q ? LATENCY : ORPHAN;
      rec_q.tile         <= TILE_ID;
      rec_q.cycles       <= start_open_q ?
                            cycles_t'(i_stamp - start_stamp_q - SENTINEL_OVERHEAD) : '0;
    end
  end

  assign o_pair_valid = pair_pend_q;
  assign o_pair       = pair_q;
  assign o_rec_valid  = rec_pend_q;
  assign o_rec        = rec_q;
  assign o_overflow   = overflow_q;

  // A stalled record must hold its value until the arbiter takes it
  a_rec_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rec_valid && !i_rec_ready |=> o_rec_valid && $stable(o_rec));

endmodule

//--- sync_aggregator.sv
`timescale 1ns/10ps

module sync_aggregator #(
  parameter int unsigned N_TILES_X = 2,
  parameter int unsigned N_TILES_Y = 2
)(
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic [N_TILES_X*N_TILES_Y-1:0] i_pair_valid,
  input  report_pkg::pair_t         i_pair [N_TILES_X*N_TILES_Y],
  output logic [N_TILES_X*N_TILES_Y-1:0] o_pair_ready,
  output logic                      o_sync_valid,
  output report_pkg::report_t       o_sync,
  input  logic                      i_sync_ready
);
  import profiler_cfg_pkg::*;
  import report_pkg::*;

  localparam int unsigned N_TILES = N_TILES_X * N_TILES_Y;
  localparam int unsigned IDX_W   = (N_TILES > 1) ? $clog2(N_TILES) : 1;
  localparam int unsigned COL_W   = (N_TILES_X > 1) ? $clog2(N_TILES_X) : 1;

  typedef enum logic [1:0] {
    COLLECT,
    SCAN,
    EMIT_GLOBAL,
    EMIT_ROW
  } state_e;

  state_e             state_q;
  logic [N_TILES-1:0] done_q;
  logic [IDX_W-1:0]   scan_idx_q;
  logic [COL_W-1:0]   col_q;
  tile_id_t           round_q;

  pair_t  pair_q [N_TILES];
  stamp_t glob_start_q;
  stamp_t glob_end_q;
  stamp_t row_start_q;
  stamp_t row_end_q;
  stamp_t row_best_q;

  pair_t  cur;
  stamp_t row_start_nxt;
  stamp_t row_end_nxt;
  stamp_t row_fig;
  stamp_t glob_fig;
  logic   scan_last;
  logic   row_last;

  // Tiles are scanned in row-major order, so rows finish one after another
  assign cur       = pair_q[scan_idx_q];
  assign scan_last = (scan_idx_q == IDX_W'(N_TILES - 1));
  assign row_last  = (col_q == COL_W'(N_TILES_X - 1));

  assign row_start_nxt = (col_q == '0 || cur.start_stamp > row_start_q) ?
                         cur.start_stamp : row_start_q;
  assign row_end_nxt   = (col_q == '0 || cur.end_stamp > row_end_q) ?
                         cur.end_stamp : row_end_q;
  assign row_fig       = row_end_nxt - row_start_nxt - SENTINEL_OVERHEAD;
  assign glob_fig      = glob_end_q - glob_start_q - SENTINEL_OVERHEAD;

  // One pair per tile per round
  assign o_pair_ready = (state_q == COLLECT) ? ~done_q : '0;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q    <= COLLECT;
      done_q     <= '0;
      scan_idx_q <= '0;
      col_q      <= '0;
      round_q    <= '0;
    end else begin
      case (state_q)
        COLLECT: begin
          done_q <= done_q | (i_pair_valid & o_pair_ready);
          if (&done_q) begin
            state_q    <= SCAN;
            done_q     <= '0;
            scan_idx_q <= '0;
            col_q      <= '0;
          end
        end
        SCAN: begin
          scan_idx_q <= scan_idx_q + 1'b1;
          col_q      <= row_last ? '0 : col_q + 1'b1;
          if (scan_last) state_q <= EMIT_GLOBAL;
        end
        EMIT_GLOBAL: begin
          if (i_sync_ready) state_q <= EMIT_ROW;
        end
        EMIT_ROW: begin
          // Round closes here and the next one opens
          if (i_sync_ready) begin
            state_q <= COLLECT;
            round_q <= round_q + 1'b1;
          end
        end
        default: state_q <= COLLECT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < N_TILES; t++) begin
      if (i_pair_valid[t] && o_pair_ready[t]) pair_q[t] <= i_pair[t];
    end
    if (state_q == COLLECT) begin
      glob_start_q <= '0;
      glob_end_q   <= '0;
      row_best_q   <= '0;
    end else if (state_q == SCAN) begin
      if (cur.start_stamp > glob_start_q) glob_start_q <= cur.start_stamp;
      if (cur.end_stamp > glob_end_q) glob_end_q <= cur.end_stamp;
      row_start_q <= row_start_nxt;
      row_end_q   <= row_end_nxt;
      if (row_last && row_fig > row_best_q) row_best_q <= row_fig;
    end
  end

  assign o_sync_valid = (state_q == EMIT_GLOBAL) || (state_q == EMIT_ROW);

  always_comb begin
    o_sync.tile = round_q;
    if (state_q == EMIT_ROW) begin
      o_sync.kind   = SYNC_ROW;
      o_sync.cycles = cycles_t'(row_best_q);
    end else begin
      o_sync.kind   = SYNC_GLOBAL;
      o_sync.cycles = cycles_t'(glob_fig);
    end
  end

  // Done bits are cleared on leaving COLLECT and gated until the round reopens
  a_done_in_collect: assert property (@(posedge clk) disable iff (!i_rst_n)
    (state_q != COLLECT) |-> (done_q == '0));

endmodule

//--- report_arbiter.sv
`timescale 1ns/10ps

module report_arbiter #(
  parameter int unsigned N_SOURCES = 5
)(
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic [N_SOURCES-2:0]   i_rec_valid,
  input  report_pkg::report_t    i_rec [N_SOURCES-1],
  output logic [N_SOURCES-2:0]   o_rec_ready,
  input  logic                   i_sync_valid,
  input  report_pkg::report_t    i_sync,
  output logic                   o_sync_ready,
  output logic                   o_out_valid,
  output report_pkg::report_t    o_out,
  input  logic                   i_out_ready
);
  import report_pkg::*;

  localparam int unsigned PTR_W = (N_SOURCES > 1) ? $clog2(N_SOURCES) : 1;

  logic [N_SOURCES-1:0] req;
  logic [N_SOURCES-1:0] gnt;
  report_t              src [N_SOURCES];
  logic [PTR_W-1:0]     ptr_q;
  logic [PTR_W-1:0]     gnt_idx;
  logic                 any_req;
  logic                 load;
  logic                 out_valid_q;
  report_t              out_q;

  // Sync source sits after the tiles
  assign req = {i_sync_valid, i_rec_valid};

  always_comb begin
    for (int s = 0; s < N_SOURCES - 1; s++) src[s] = i_rec[s];
    src[N_SOURCES-1] = i_sync;
  end

  // Output register takes a new record when empty or draining
  assign load = !out_valid_q || i_out_ready;

  always_comb begin : pick
    int unsigned idx;
    any_req = 1'b0;
    gnt_idx = ptr_q;
    gnt     = '0;
    for (int unsigned k = 0; k < N_SOURCES; k++) begin
      idx = (int'(ptr_q) + k) % N_SOURCES;
      if (!any_req && req[idx]) begin
        any_req = 1'b1;
        gnt_idx = PTR_W'(idx);
      end
    end
    if (any_req && load) gnt[gnt_idx] = 1'b1;
  end

  assign o_rec_ready  = gnt[N_SOURCES-2:0];
  assign o_sync_ready = gnt[N_SOURCES-1];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      out_valid_q <= 1'b0;
      ptr_q       <= '0;
    end else if (load) begin
      out_valid_q <= any_req;
      if (any_req) begin
        ptr_q <= (gnt_idx == PTR_W'(N_SOURCES - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && any_req) out_q <= src[gnt_idx];
  end

  assign o_out_valid = out_valid_q;
  assign o_out       = out_q;

endmodule

//--- credit_tx_queue.sv
`timescale 1ns/10ps

module credit_tx_queue #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned CREDITS     = 4
)(
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_in_valid,
  input  report_pkg::report_t i_in,
  output logic                o_in_ready,
  output logic                o_rpt_valid,
  output report_pkg::report_t o_rpt,
  input  logic                i_rpt_credit
);
  import report_pkg::*;

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int unsigned CRD_W = $clog2(CREDITS + 1);

  report_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] credit_q;
  logic             push;
  logic             pop;

  assign o_in_ready = (count_q != CNT_W'(QUEUE_DEPTH));
  assign push       = i_in_valid && o_in_ready;

  // Receiver always accepts, so a presented report is a sent report
  assign o_rpt_valid = (count_q != '0) && (credit_q != '0);
  assign pop         = o_rpt_valid;
  assign o_rpt       = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= i_in;
  end

  // Credit in and report out in one cycle cancel
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credit_q <= CRD_W'(CREDITS);
    end else begin
      case ({i_rpt_credit, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Spending the last credit silences the port until a credit returns
  a_no_send_without_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rpt_valid && (credit_q == CRD_W'(1)) && !i_rpt_credit |=> !o_rpt_valid);

  // Receiver returns no more credits than it was granted
  a_credit_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
    credit_q <= CRD_W'(CREDITS));

endmodule

//--- sync_profiler_top.sv
`timescale 1ns/10ps

module sync_profiler_top #(
  parameter int unsigned N_TILES_X   = 2,
  parameter int unsigned N_TILES_Y   = 2,
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned CREDITS     = 4
)(
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  report_pkg::wb_beat_t i_wb [N_TILES_X*N_TILES_Y],
  input  logic                 i_rpt_credit,
  output logic                 o_rpt_valid,
  output report_pkg::report_t  o_rpt,
  output logic                 o_overflow
);
  import profiler_cfg_pkg::*;
  import report_pkg::*;

  localparam int unsigned N_TILES = N_TILES_X * N_TILES_Y;

  stamp_t             timer_q;
  logic [N_TILES-1:0] pair_valid;
  logic [N_TILES-1:0] pair_ready;
  logic [N_TILES-1:0] rec_valid;
  logic [N_TILES-1:0] rec_ready;
  logic [N_TILES-1:0] overflow;
  pair_t              pairs [N_TILES];
  report_t            recs [N_TILES];
  logic               sync_valid;
  logic               sync_ready;
  report_t            sync_rec;
  logic               arb_valid;
  logic               arb_ready;
  report_t            arb_rec;

  // Shared cycle timer
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
    sentinel_tracker #(
      .TILE_ID (tile_id_t'(t))
    ) u_tracker (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_beat       (i_wb[t]),
      .i_stamp      (timer_q),
      .o_pair_valid (pair_valid[t]),
      .o_pair       (pairs[t]),
      .i_pair_ready (pair_ready[t]),
      .o_rec_valid  (rec_valid[t]),
      .o_rec        (recs[t]),
      .i_rec_ready  (rec_ready[t]),
      .o_overflow   (overflow[t])
    );
  end

  sync_aggregator #(
    .N_TILES_X (N_TILES_X),
    .N_TILES_Y (N_TILES_Y)
  ) u_aggregator (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_pair_valid (pair_valid),
    .i_pair       (pairs),
    .o_pair_ready (pair_ready),
    .o_sync_valid (sync_valid),
    .o_sync       (sync_rec),
    .i_sync_ready (sync_ready)
  );

  report_arbiter #(
    .N_SOURCES (N_TILES + 1)
  ) u_arbiter (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_rec_valid  (rec_valid),
    .i_rec        (recs),
    .o_rec_ready  (rec_ready),
    .i_sync_valid (sync_valid),
    .i_sync       (sync_rec),
    .o_sync_ready (sync_ready),
    .o_out_valid  (arb_valid),
    .o_out        (arb_rec),
    .i_out_ready  (arb_ready)
  );

  credit_tx_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .CREDITS     (CREDITS)
  ) u_queue (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_in_valid   (arb_valid),
    .i_in         (arb_rec),
    .o_in_ready   (arb_ready),
    .o_rpt_valid  (o_rpt_valid),
    .o_rpt        (o_rpt),
    .i_rpt_credit (i_rpt_credit)
  );

  assign o_overflow = |overflow;

endmodule

//--- tb_sync_profiler.sv
`timescale 1ns/10ps

module tb_sync_profiler;
  import profiler_cfg_pkg::*;
  import report_pkg::*;

  localparam int NX      = 2;
  localparam int NY      = 2;
  localparam int N_TILES = NX * NY;
  localparam int N_SRC   = N_TILES + 1;
  localparam int DEPTH   = 4;
  localparam int CREDITS = 4;

  logic     clk;
  logic     rst_n;
  wb_beat_t wb [N_TILES];
  logic     rpt_credit = 1'b0;
  logic     rpt_valid;
  report_t  rpt;
  logic     overflow;

  // Expected reports, one queue per tile and the last one for sync
  report_t exp_q [N_SRC][$];
  int      rx_count [N_SRC];
  integer  seed;
  int      cycle_cnt  = 0;
  int      n_beats    = 0;
  int      round_idx  = 0;
  int      fail_count = 0;
  int      held       = CREDITS;
  int      owed       = 0;
  bit      withhold   = 1'b0;

  sync_profiler_top #(
    .N_TILES_X   (NX),
    .N_TILES_Y   (NY),
    .QUEUE_DEPTH (DEPTH),
    .CREDITS     (CREDITS)
  ) uut (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_wb         (wb),
    .i_rpt_credit (rpt_credit),
    .o_rpt_valid  (rpt_valid),
    .o_rpt        (rpt),
    .o_overflow   (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      fail_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    fail_count++;
    $display("ERROR at %0t: %s", $time, why);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  // Expected report built only from beat cycle differences
  function automatic report_t expected_report(report_kind_e kind, int idx,
                                              int st [N_TILES], int en [N_TILES]);
    report_t r;
    int max_st;
    int max_en;
    int fig;
    int best;
    r.kind   = kind;
    r.tile   = tile_id_t'(idx);
    r.cycles = '0;
    case (kind)
      // Sentinel overhead of one cycle comes off every figure
      LATENCY: r.cycles = cycles_t'(en[idx] - st[idx] - 1);
      SYNC_GLOBAL: begin
        max_st = st[0];
        max_en = en[0];
        for (int t = 1; t < N_TILES; t++) begin
          if (st[t] > max_st) max_st = st[t];
          if (en[t] > max_en) max_en = en[t];
        end
        r.cycles = cycles_t'(max_en - max_st - 1);
      end
      SYNC_ROW: begin
        best = 0;
        for (int y = 0; y < NY; y++) begin
          max_st = st[y*NX];
          max_en = en[y*NX];
          for (int x = 1; x < NX; x++) begin
            if (st[y*NX+x] > max_st) max_st = st[y*NX+x];
            if (en[y*NX+x] > max_en) max_en = en[y*NX+x];
          end
          fig = max_en - max_st - 1;
          if (fig > best) best = fig;
        end
        r.cycles = cycles_t'(best);
      end
      default: r.cycles = '0;
    endcase
    return r;
  endfunction

  function int rand_gap();
    return 1 + ($random(seed) & 7);
  endfunction

  task automatic clear_beats();
    for (int t = 0; t < N_TILES; t++) wb[t] = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Called on a falling edge, returns on the next one with the beat removed
  task automatic send_beat(input int tile, input instr_t instr, output int cyc);
    clear_beats();
    wb[tile].valid = 1'b1;
    wb[tile].instr = instr;
    cyc = cycle_cnt;
    n_beats++;
    @(negedge clk);
    clear_beats();
  endtask

  // Returns once every expected report arrived and every credit went back
  task automatic wait_drained();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = (held != CREDITS);
      for (int s = 0; s < N_SRC; s++) begin
        if (exp_q[s].size() != 0) busy = 1'b1;
      end
    end
    @(negedge clk);
  endtask

  task automatic run_round(input bit restart);
    int st [N_TILES];
    int en [N_TILES];
    int t;
    for (int k = 0; k < N_TILES; k++) begin
      send_beat(k, SENTINEL_START, st[k]);
      idle(rand_gap());
    end
    // Second start moves the measurement to the later stamp
    if (restart) begin
      for (int k = 0; k < N_TILES; k++) begin
        send_beat(k, SENTINEL_START, st[k]);
        idle(rand_gap());
      end
    end
    for (int k = 0; k < N_TILES; k++) begin
      t = N_TILES - 1 - k;
      send_beat(t, SENTINEL_END, en[t]);
      exp_q[t].push_back(expected_report(LATENCY, t, st, en));
      idle(rand_gap());
    end
    exp_q[N_TILES].push_back(expected_report(SYNC_GLOBAL, round_idx, st, en));
    exp_q[N_TILES].push_back(expected_report(SYNC_ROW, round_idx, st, en));
    round_idx++;
    wait_drained();
  endtask

  task automatic stall_phase();
    int st [N_TILES];
    int en [N_TILES];
    int base;
    base = rx_count[0];
    withhold = 1'b1;
    // Orphans on the other tiles use up most of the credits
    for (int t = 1; t < N_TILES; t++) begin
      send_beat(t, SENTINEL_END, en[t]);
      exp_q[t].push_back(expected_report(ORPHAN, t, st, en));
      idle(rand_gap());
    end
    for (int k = 0; k < 6; k++) begin
      send_beat(0, SENTINEL_START, st[0]);
      idle(rand_gap());
      send_beat(0, SENTINEL_END, en[0]);
      exp_q[0].push_back(expected_report(LATENCY, 0, st, en));
      idle(rand_gap());
    end
    idle(2);
    check_value("o_overflow", 32'(overflow), 32'd1);
    while (held != 0) @(posedge clk);
    withhold = 1'b0;
    // Tile 0 gets its first two records out, later ends are dropped
    while (rx_count[0] < base + 2 || held != CREDITS) @(posedge clk);
    for (int s = 1; s < N_SRC; s++) begin
      if (exp_q[s].size() != 0) begin
        abort_run($sformatf("source %0d still waits for %0d reports", s, exp_q[s].size()));
      end
    end
    @(negedge clk);
  endtask

  // Receiver returns each credit one cycle after its report
  always @(negedge clk) begin : rx
    report_t want;
    int      src;
    bit      is_sync;
    if (rst_n) begin
      if (rpt_valid && held == 0) begin
        abort_run("report presented while the testbench holds no credit");
      end
      rpt_credit = 1'b0;
      if (owed > 0 && !withhold) begin
        rpt_credit = 1'b1;
        owed--;
        held++;
      end
      if (rpt_valid) begin
        held--;
        owed++;
        is_sync = (rpt.kind == SYNC_GLOBAL) || (rpt.kind == SYNC_ROW);
        src     = is_sync ? N_TILES : int'(rpt.tile);
        if (!is_sync && int'(rpt.tile) >= N_TILES) begin
          abort_run($sformatf("report names tile %0d outside the grid", rpt.tile));
        end else if (exp_q[src].size() == 0) begin
          abort_run($sformatf("report from source %0d with nothing expected", src));
        end else begin
          want = exp_q[src].pop_front();
          rx_count[src]++;
          check_value("o_rpt.kind", 32'(rpt.kind), 32'(want.kind));
          check_value("o_rpt.tile", 32'(rpt.tile), 32'(want.tile));
          check_value("o_rpt.cycles", 32'(rpt.cycles), 32'(want.cycles));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > 40 * n_beats + 2000) begin
      abort_run($sformatf("timeout after %0d cycles, %0d beats driven", cycle_cnt, n_beats));
    end
  end

  initial begin
    int st [N_TILES];
    int en [N_TILES];
    seed  = 32'hbeae_c241;
    rst_n = 1'b0;
    clear_beats();
    for (int s = 0; s < N_SRC; s++) rx_count[s] = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    run_round(1'b0);
    // Ends without a start give orphans and leave the round alone
    for (int t = 0; t < N_TILES; t++) begin
      send_beat(t, SENTINEL_END, en[t]);
      exp_q[t].push_back(expected_report(ORPHAN, t, st, en));
      idle(rand_gap());
    end
    wait_drained();
    run_round(1'b0);
    run_round(1'b0);
    run_round(1'b1);
    check_value("o_overflow", 32'(overflow), 32'd0);
    stall_phase();
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
profiler_cfg_pkg.sv
report_pkg.sv
sentinel_tracker.sv
sync_aggregator.sv
report_arbiter.sv
credit_tx_queue.sv
sync_profiler_top.sv
tb_sync_profiler.sv

//--- Makefile
TOP := tb_sync_profiler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
